// ==== dv/aluCoreTb.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"

module aluCoreTb;

    localparam int NumFixed = 38;
    localparam int NumRand  = 12;
    localparam int NumTests = NumFixed + NumRand;
    // Division is the slowest operation at about 36 cycles
    localparam int TimeoutCycles = (NumTests + 4) * 40;
    localparam int MaxWait = 40;

    logic                   Clock;
    logic                   arstN;
    logic                   start;
    logic [`FUNC_WIDTH-1:0] funcCode;
    aluPkg::dataWordT       operandA;
    aluPkg::dataWordT       operandB;
    logic                   busy;
    logic                   done;
    aluPkg::dataWordT       result;

    string                  testName [NumTests];
    logic [`FUNC_WIDTH-1:0] testCode [NumTests];
    aluPkg::dataWordT       testA    [NumTests];
    aluPkg::dataWordT       testB    [NumTests];
    aluPkg::dataWordT       testExp  [NumTests];
    int                     tableLen;
    int                     passCount;
    int                     failCount;
    int                     cycleCount;
    logic [31:0]            lfsrState;

    aluCore dut_i (
        .Clock(Clock), .arstN(arstN), .start(start), .funcCode(funcCode),
        .operandA(operandA), .operandB(operandB),
        .busy(busy), .done(done), .result(result)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
        $display("ERRORS FOUND");
        $finish;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randWord(output aluPkg::dataWordT w);
        int i;
        w = '0;
        for (i = 0; i < 32; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    // Truncating division with the remainder taking the dividend's sign
    function automatic aluPkg::dataWordT divModel(input aluPkg::dataWordT a,
                                                  input aluPkg::dataWordT b,
                                                  input logic wantMod);
        aluPkg::dataWordT magA;
        aluPkg::dataWordT magB;
        aluPkg::dataWordT q;
        aluPkg::dataWordT r;
        if (b == '0) begin
            return wantMod ? a : '1;
        end
        magA = a[31] ? -a : a;
        magB = b[31] ? -b : b;
        q = magA / magB;
        r = magA % magB;
        if (wantMod) begin
            return a[31] ? -r : r;
        end
        return (a[31] ^ b[31]) ? -q : q;
    endfunction

    // Largest r with r*r <= a built one bit at a time
    function automatic aluPkg::dataWordT sqrtModel(input aluPkg::dataWordT a);
        aluPkg::dataWordT r;
        aluPkg::dataWordT c;
        logic [63:0]      sq;
        int               bitIdx;
        r = '0;
        for (bitIdx = `SQRT_STEPS - 1; bitIdx >= 0; bitIdx--) begin
            c = r | (32'd1 << bitIdx);
            sq = {32'd0, c} * {32'd0, c};
            if (sq <= {32'd0, a}) begin
                r = c;
            end
        end
        return r;
    endfunction

    function automatic bit isSimpleCode(input logic [`FUNC_WIDTH-1:0] code);
        return (code != aluPkg::intDiv) && (code != aluPkg::intMod) &&
               (code != aluPkg::intSqrtOp);
    endfunction

    task automatic addTest(input string name, input logic [`FUNC_WIDTH-1:0] code,
                           input aluPkg::dataWordT a, input aluPkg::dataWordT b,
                           input aluPkg::dataWordT expected);
        testName[tableLen] = name;
        testCode[tableLen] = code;
        testA[tableLen]    = a;
        testB[tableLen]    = b;
        testExp[tableLen]  = expected;
        tableLen++;
    endtask

    task automatic buildTable();
        int               i;
        aluPkg::dataWordT a;
        aluPkg::dataWordT b;
        addTest("add_wrap", aluPkg::intAdd, 32'h7fffffff, 32'h00000001, 32'h80000000);
        addTest("add_carry", aluPkg::intAdd, 32'hffffffff, 32'h00000002, 32'h00000001);
        addTest("sub_neg", aluPkg::intSub, 32'h00000005, 32'h00000007, 32'hfffffffe);
        addTest("mul_wrap", aluPkg::intMul, 32'h00010001, 32'h00010001, 32'h00020001);
        addTest("mul_neg", aluPkg::intMul, 32'hffffffff, 32'h00000003, 32'hfffffffd);
        addTest("cmp_gt_signed", aluPkg::cmpGt, 32'h00000001, 32'hffffffff, 32'h1);
        addTest("cmp_gt_unsigned", aluPkg::cmpGtU, 32'h00000001, 32'hffffffff, 32'h0);
        addTest("cmp_lt_signed", aluPkg::cmpLt, 32'h80000000, 32'h00000000, 32'h1);
        addTest("cmp_lt_unsigned", aluPkg::cmpLtU, 32'h80000000, 32'h00000000, 32'h0);
        addTest("cmp_eq", aluPkg::cmpEq, 32'h00001234, 32'h00001234, 32'h1);
        addTest("cmp_ne", aluPkg::cmpNe, 32'h00001234, 32'h00001234, 32'h0);
        addTest("logic_not", aluPkg::logicNot, 32'h0f0f00ff, 32'h0, 32'hf0f0ff00);
        addTest("logic_and", aluPkg::logicAnd, 32'hff00ff00, 32'h0ff00ff0, 32'h0f000f00);
        addTest("logic_or", aluPkg::logicOr, 32'hff00ff00, 32'h0ff00ff0, 32'hfff0fff0);
        addTest("logic_xor", aluPkg::logicXor, 32'hff00ff00, 32'h0ff00ff0, 32'hf0f0f0f0);
        addTest("logic_xnor", aluPkg::logicXnor, 32'hff00ff00, 32'h0ff00ff0, 32'h0f0f0f0f);
        addTest("shl_logic", aluPkg::shiftLeftLogic, 32'h00000001, 32'h00000021, 32'h2);
        addTest("shl_arith", aluPkg::shiftLeftArith, 32'h80000003, 32'h00000064, 32'h00000030);
        addTest("shr_arith", aluPkg::shiftRightArith, 32'h80000000, 32'hffffff44, 32'hf8000000);
        addTest("shr_logic", aluPkg::shiftRightLogic, 32'h80000000, 32'hffffffe4, 32'h08000000);
        addTest("unknown_code", 6'd21, 32'h00000005, 32'h00000006, 32'h0);
        addTest("div_pos_pos", aluPkg::intDiv, 32'h00000007, 32'h00000002, 32'h00000003);
        addTest("div_neg_pos", aluPkg::intDiv, 32'hfffffff9, 32'h00000002, 32'hfffffffd);
        addTest("div_pos_neg", aluPkg::intDiv, 32'h00000007, 32'hfffffffe, 32'hfffffffd);
        addTest("div_neg_neg", aluPkg::intDiv, 32'hfffffff9, 32'hfffffffe, 32'h00000003);
        addTest("mod_pos_pos", aluPkg::intMod, 32'h00000007, 32'h00000002, 32'h00000001);
        addTest("mod_neg_pos", aluPkg::intMod, 32'hfffffff9, 32'h00000002, 32'hffffffff);
        addTest("mod_pos_neg", aluPkg::intMod, 32'h00000007, 32'hfffffffe, 32'h00000001);
        addTest("mod_neg_neg", aluPkg::intMod, 32'hfffffff9, 32'hfffffffe, 32'hffffffff);
        addTest("div_by_zero", aluPkg::intDiv, 32'h12345678, 32'h0, 32'hffffffff);
        addTest("mod_by_zero", aluPkg::intMod, 32'hfedcba98, 32'h0, 32'hfedcba98);
        addTest("div_min_by_m1", aluPkg::intDiv, 32'h80000000, 32'hffffffff, 32'h80000000);
        addTest("mod_min_by_m1", aluPkg::intMod, 32'h80000000, 32'hffffffff, 32'h0);
        addTest("sqrt_square", aluPkg::intSqrtOp, 32'd144, 32'h0, 32'd12);
        addTest("sqrt_pow2", aluPkg::intSqrtOp, 32'h40000000, 32'h0, 32'h00008000);
        addTest("sqrt_nonsquare", aluPkg::intSqrtOp, 32'd99, 32'h0, 32'd9);
        addTest("sqrt_all_ones", aluPkg::intSqrtOp, 32'hffffffff, 32'h0, 32'h0000ffff);
        addTest("sqrt_zero", aluPkg::intSqrtOp, 32'h0, 32'h0, 32'h0);
        for (i = 0; i < NumRand; i++) begin
            randWord(a);
            randWord(b);
            // Shorter divisors give quotients of varied size
            b = $signed(b) >>> (i + 4);
            case (i % 3)
                0: addTest($sformatf("rand_div_%0d", i), aluPkg::intDiv, a, b,
                           divModel(a, b, 1'b0));
                1: addTest($sformatf("rand_mod_%0d", i), aluPkg::intMod, a, b,
                           divModel(a, b, 1'b1));
                default: addTest($sformatf("rand_sqrt_%0d", i), aluPkg::intSqrtOp, a, '0,
                                 sqrtModel(a));
            endcase
        end
    endtask

    task automatic nextEdge();
        @(posedge Clock);
        #1;
    endtask

    task automatic recordTest(input string name, input bit ok);
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("%-20s %s", name, ok ? "pass" : "fail");
    endtask

    task automatic checkResetState();
        bit ok;
        ok = 1'b1;
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("reset_state: busy or done not low after reset");
            ok = 1'b0;
        end
        if (result !== '0) begin
            $display("FAILED reset_state expected %h actual %h", 32'h0, result);
            ok = 1'b0;
        end
        recordTest("reset_state", ok);
    endtask

    // Returns in the done cycle, so the next call issues back to back
    task automatic runOp(input int idx);
        int edges;
        bit ok;
        bit seen;
        ok = 1'b1;
        seen = 1'b0;
        start = 1'b1;
        funcCode = testCode[idx];
        operandA = testA[idx];
        operandB = testB[idx];
        nextEdge();
        start = 1'b0;
        if (busy !== 1'b1) begin
            $display("%s: busy did not rise after start", testName[idx]);
            ok = 1'b0;
        end
        edges = 0;
        while (!seen && edges < MaxWait) begin
            nextEdge();
            edges++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("%s: no done within %0d cycles", testName[idx], MaxWait);
            ok = 1'b0;
        end else begin
            if (isSimpleCode(testCode[idx]) && edges != 2) begin
                $display("%s: done came %0d edges after acceptance instead of 2",
                         testName[idx], edges);
                ok = 1'b0;
            end
            if (result !== testExp[idx]) begin
                $display("FAILED %s expected %h actual %h", testName[idx], testExp[idx], result);
                ok = 1'b0;
            end
        end
        recordTest(testName[idx], ok);
    endtask

    task automatic startWhileBusy();
        int               edges;
        int               doneCount;
        bit               ok;
        aluPkg::dataWordT gotResult;
        ok = 1'b1;
        doneCount = 0;
        gotResult = '0;
        start = 1'b1;
        funcCode = aluPkg::intDiv;
        operandA = 32'd100;
        operandB = 32'd7;
        nextEdge();
        start = 1'b0;
        for (edges = 0; edges < 60 && doneCount == 0; edges++) begin
            // Second request in the middle of the division
            if (edges == 5) begin
                start = 1'b1;
                funcCode = aluPkg::intAdd;
                operandA = 32'd1;
                operandB = 32'd2;
            end else begin
                start = 1'b0;
            end
            nextEdge();
            if (done === 1'b1) begin
                doneCount++;
                gotResult = result;
            end
        end
        start = 1'b0;
        if (doneCount == 0) begin
            $display("start_while_busy: no done within 60 cycles");
            ok = 1'b0;
        end
        nextEdge();
        if (busy !== 1'b0) begin
            $display("start_while_busy: busy still high after done");
            ok = 1'b0;
        end
        repeat (4) begin
            if (done === 1'b1) begin
                doneCount++;
            end
            nextEdge();
        end
        if (doneCount > 1) begin
            $display("start_while_busy: done pulsed %0d times instead of once", doneCount);
            ok = 1'b0;
        end
        if (doneCount > 0 && gotResult !== 32'd14) begin
            $display("FAILED start_while_busy expected %h actual %h", 32'd14, gotResult);
            ok = 1'b0;
        end
        recordTest("start_while_busy", ok);
    endtask

    initial begin
        int idx;
        start = 1'b0;
        funcCode = '0;
        operandA = '0;
        operandB = '0;
        arstN = 1'b0;
        passCount = 0;
        failCount = 0;
        tableLen = 0;
        lfsrState = 32'h1759_aafd;
        buildTable();
        repeat (2) @(posedge Clock);
        #1;
        arstN = 1'b1;
        checkResetState();
        for (idx = 0; idx < tableLen; idx++) begin
            runOp(idx);
        end
        startWhileBusy();
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps -f sim.f --top-module aluCoreTb -o aluCoreSim
obj_dir/aluCoreSim > sim.log
cat sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== sim.f ====
+incdir+src
src/aluPkg.sv
src/issueStage.sv
src/simpleAlu.sv
src/seqDivider.sv
src/intSqrt.sv
src/retireStage.sv
src/aluCore.sv
dv/aluCoreTb.sv

// ==== src/aluCore.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"

module aluCore (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   start,
    input  logic [`FUNC_WIDTH-1:0] funcCode,
    input  aluPkg::dataWordT       operandA,
    input  aluPkg::dataWordT       operandB,
    output logic                   busy,
    output logic                   done,
    output aluPkg::dataWordT       result
);

    aluPkg::funcCodeT opFunc;
    aluPkg::dataWordT opA;
    aluPkg::dataWordT opB;
    aluPkg::unitSelT  unitSel;
    logic             simpleIssue;
    logic             divStart;
    logic             sqrtStart;
    aluPkg::dataWordT simpleResult;
    logic             divDone;
    aluPkg::dataWordT quotient;
    aluPkg::dataWordT remainder;
    logic             sqrtDone;
    aluPkg::dataWordT root;

    // Unlisted codes pass through and come back as zero
    issueStage issueInst (
        .Clock(Clock), .arstN(arstN), .start(start),
        .funcCode(aluPkg::funcCodeT'(funcCode)),
        .operandA(operandA), .operandB(operandB), .done(done),
        .busy(busy), .opFunc(opFunc), .opA(opA), .opB(opB), .unitSel(unitSel),
        .simpleIssue(simpleIssue), .divStart(divStart), .sqrtStart(sqrtStart)
    );

    simpleAlu simpleInst (
        .opFunc(opFunc), .opA(opA), .opB(opB), .simpleResult(simpleResult)
    );

    seqDivider divInst (
        .Clock(Clock), .arstN(arstN), .divStart(divStart), .opA(opA), .opB(opB),
        .divDone(divDone), .quotient(quotient), .remainder(remainder)
    );

    intSqrt sqrtInst (
        .Clock(Clock), .arstN(arstN), .sqrtStart(sqrtStart), .opA(opA),
        .sqrtDone(sqrtDone), .root(root)
    );

    retireStage retireInst (
        .Clock(Clock), .arstN(arstN), .unitSel(unitSel), .opFunc(opFunc),
        .simpleIssue(simpleIssue), .simpleResult(simpleResult),
        .divDone(divDone), .quotient(quotient), .remainder(remainder),
        .sqrtDone(sqrtDone), .root(root), .done(done), .result(result)
    );

endmodule

// ==== src/aluPkg.sv ====
`include "alu_defs.svh"

package aluPkg;

    typedef logic [`DATA_WIDTH-1:0] dataWordT;

    // Codes follow the processor's instruction encoding
    typedef enum logic [`FUNC_WIDTH-1:0] {
        intAdd          = 6'd0,
        intSub          = 6'd1,
        intMul          = 6'd2,
        intSqrtOp       = 6'd3,
        intDiv          = 6'd4,
        intMod          = 6'd5,
        shiftLeftArith  = 6'd6,
        shiftRightArith = 6'd7,
        cmpEq           = 6'd8,
        cmpNe           = 6'd9,
        cmpGt           = 6'd10,
        cmpLt           = 6'd11,
        cmpGtU          = 6'd12,
        cmpLtU          = 6'd13,
        logicNot        = 6'd16,
        logicAnd        = 6'd17,
        logicOr         = 6'd18,
        logicXor        = 6'd19,
        logicXnor       = 6'd20,
        shiftLeftLogic  = 6'd22,
        shiftRightLogic = 6'd23
    } funcCodeT;

    typedef enum logic [1:0] {unitSimple, unitDiv, unitSqrt} unitSelT;

    typedef enum logic [1:0] {divIdle, divRun, divFix} divStateT;

    typedef enum logic {sqrtIdle, sqrtRun} sqrtStateT;

endpackage

// ==== src/alu_defs.svh ====
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand and result width
`define DATA_WIDTH 32
`define FUNC_WIDTH 6

// Iteration counts of the sequential units
`define DIV_STEPS  32
`define SQRT_STEPS 16

`endif

// ==== src/intSqrt.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"

module intSqrt (
    input  logic             Clock,
    input  logic             arstN,
    input  logic             sqrtStart,
    input  aluPkg::dataWordT opA,
    output logic             sqrtDone,
    output aluPkg::dataWordT root
);

    localparam int RootW  = `SQRT_STEPS;
    localparam int CountW = $clog2(`SQRT_STEPS);

    aluPkg::sqrtStateT state;
    logic [CountW-1:0] stepCount;
    logic              lastStep;
    aluPkg::dataWordT  radReg;
    logic [RootW-1:0]  rootAcc;
    logic [RootW+1:0]  remReg;
    logic [RootW+3:0]  partial;
    logic [RootW+3:0]  trial;
    logic [RootW+3:0]  diff;
    logic              fits;
    logic [RootW-1:0]  rootNext;

    assign lastStep = stepCount == CountW'(`SQRT_STEPS - 1);

    // Bring down two radicand bits and test 4*root+1
    assign partial  = {remReg, radReg[`DATA_WIDTH-1 -: 2]};
    assign trial    = {2'b00, rootAcc, 2'b01};
    assign fits     = partial >= trial;
    assign diff     = partial - trial;
    assign rootNext = {rootAcc[RootW-2:0], fits};

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state     <= aluPkg::sqrtIdle;
            stepCount <= '0;
            sqrtDone  <= 1'b0;
        end else begin
            sqrtDone <= 1'b0;
            if (state == aluPkg::sqrtIdle) begin
                if (sqrtStart) begin
                    state     <= aluPkg::sqrtRun;
                    stepCount <= '0;
                end
            end else begin
                stepCount <= stepCount + 1'b1;
                if (lastStep) begin
                    state    <= aluPkg::sqrtIdle;
                    sqrtDone <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (state == aluPkg::sqrtIdle) begin
            if (sqrtStart) begin
                radReg  <= opA;
                rootAcc <= '0;
                remReg  <= '0;
            end
        end else begin
            radReg  <= radReg << 2;
            rootAcc <= rootNext;
            remReg  <= fits ? diff[RootW+1:0] : partial[RootW+1:0];
            if (lastStep) begin
                root <= aluPkg::dataWordT'(rootNext);
            end
        end
    end

endmodule

// ==== src/issueStage.sv ====
`timescale 1ns/10ps

module issueStage (
    input  logic             Clock,
    input  logic             arstN,
    input  logic             start,
    input  aluPkg::funcCodeT funcCode,
    input  aluPkg::dataWordT operandA,
    input  aluPkg::dataWordT operandB,
    input  logic             done,
    output logic             busy,
    output aluPkg::funcCodeT opFunc,
    output aluPkg::dataWordT opA,
    output aluPkg::dataWordT opB,
    output aluPkg::unitSelT  unitSel,
    output logic             simpleIssue,
    output logic             divStart,
    output logic             sqrtStart
);

    logic            accept;
    logic            launchPend;
    aluPkg::unitSelT decodedSel;

    // Slot frees up in the done cycle
    assign accept = start && (!busy || done);

    always_comb begin
        case (funcCode)
            aluPkg::intDiv, aluPkg::intMod: decodedSel = aluPkg::unitDiv;
            aluPkg::intSqrtOp:              decodedSel = aluPkg::unitSqrt;
            default:                        decodedSel = aluPkg::unitSimple;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            busy        <= 1'b0;
            launchPend  <= 1'b0;
            unitSel     <= aluPkg::unitSimple;
            simpleIssue <= 1'b0;
            divStart    <= 1'b0;
            sqrtStart   <= 1'b0;
        end else begin
            launchPend  <= accept;
            // Exactly one launch pulse per accepted operation
            simpleIssue <= launchPend && (unitSel == aluPkg::unitSimple);
            divStart    <= launchPend && (unitSel == aluPkg::unitDiv);
            sqrtStart   <= launchPend && (unitSel == aluPkg::unitSqrt);
            if (accept) begin
                busy    <= 1'b1;
                unitSel <= decodedSel;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (accept) begin
            opFunc <= funcCode;
            opA    <= operandA;
            opB    <= operandB;
        end
    end

endmodule

// ==== src/retireStage.sv ====
`timescale 1ns/10ps

module retireStage (
    input  logic             Clock,
    input  logic             arstN,
    input  aluPkg::unitSelT  unitSel,
    input  aluPkg::funcCodeT opFunc,
    input  logic             simpleIssue,
    input  aluPkg::dataWordT simpleResult,
    input  logic             divDone,
    input  aluPkg::dataWordT quotient,
    input  aluPkg::dataWordT remainder,
    input  logic             sqrtDone,
    input  aluPkg::dataWordT root,
    output logic             done,
    output aluPkg::dataWordT result
);

    logic             finish;
    aluPkg::dataWordT retireValue;

    // Only the owning unit may finish
    always_comb begin
        case (unitSel)
            aluPkg::unitSimple: begin
                finish      = simpleIssue;
                retireValue = simpleResult;
            end
            aluPkg::unitDiv: begin
                finish      = divDone;
                retireValue = (opFunc == aluPkg::intMod) ? remainder : quotient;
            end
            aluPkg::unitSqrt: begin
                finish      = sqrtDone;
                retireValue = root;
            end
            default: begin
                finish      = 1'b0;
                retireValue = '0;
            end
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= finish;
            if (finish) begin
                result <= retireValue;
            end
        end
    end

endmodule

// ==== src/seqDivider.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"

module seqDivider (
    input  logic             Clock,
    input  logic             arstN,
    input  logic             divStart,
    input  aluPkg::dataWordT opA,
    input  aluPkg::dataWordT opB,
    output logic             divDone,
    output aluPkg::dataWordT quotient,
    output aluPkg::dataWordT remainder
);

    localparam int CountW = $clog2(`DIV_STEPS);

    aluPkg::divStateT     state;
    logic [CountW-1:0]    stepCount;
    logic                 negA;
    logic                 negB;
    aluPkg::dataWordT     magA;
    aluPkg::dataWordT     magB;
    aluPkg::dataWordT     dvsMag;
    aluPkg::dataWordT     quoReg;
    aluPkg::dataWordT     remReg;
    logic [`DATA_WIDTH:0] partial;
    logic [`DATA_WIDTH:0] trial;

    assign magA = opA[`DATA_WIDTH-1] ? -opA : opA;
    assign magB = opB[`DATA_WIDTH-1] ? -opB : opB;

    // Shift in next dividend bit, then try the subtraction
    assign partial = {remReg, quoReg[`DATA_WIDTH-1]};
    assign trial   = partial - {1'b0, dvsMag};

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            state     <= aluPkg::divIdle;
            stepCount <= '0;
            divDone   <= 1'b0;
        end else begin
            divDone <= 1'b0;
            case (state)
                aluPkg::divIdle: begin
                    if (divStart) begin
                        state     <= aluPkg::divRun;
                        stepCount <= '0;
                    end
                end
                aluPkg::divRun: begin
                    stepCount <= stepCount + 1'b1;
                    if (stepCount == CountW'(`DIV_STEPS - 1)) begin
                        state <= aluPkg::divFix;
                    end
                end
                aluPkg::divFix: begin
                    state   <= aluPkg::divIdle;
                    divDone <= 1'b1;
                end
                default: begin
                    state <= aluPkg::divIdle;
                end
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        case (state)
            aluPkg::divIdle: begin
                if (divStart) begin
                    negA   <= opA[`DATA_WIDTH-1];
                    negB   <= opB[`DATA_WIDTH-1];
                    quoReg <= magA;
                    dvsMag <= magB;
                    remReg <= '0;
                end
            end
            aluPkg::divRun: begin
                // Negative trial means restore
                remReg <= trial[`DATA_WIDTH] ? partial[`DATA_WIDTH-1:0]
                                             : trial[`DATA_WIDTH-1:0];
                quoReg <= {quoReg[`DATA_WIDTH-2:0], !trial[`DATA_WIDTH]};
            end
            aluPkg::divFix: begin
                if (dvsMag == '0) begin
                    quotient <= '1;
                end else begin
                    quotient <= (negA != negB) ? -quoReg : quoReg;
                end
                // Remainder follows the dividend, so x/0 leaves x
                remainder <= negA ? -remReg : remReg;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== src/simpleAlu.sv ====
`timescale 1ns/10ps
`include "alu_defs.svh"

module simpleAlu (
    input  aluPkg::funcCodeT opFunc,
    input  aluPkg::dataWordT opA,
    input  aluPkg::dataWordT opB,
    output aluPkg::dataWordT simpleResult
);

    localparam int ShiftW = $clog2(`DATA_WIDTH);

    logic [ShiftW-1:0] shamt;

    // Only the low bits count as shift amount
    assign shamt = opB[ShiftW-1:0];

    always_comb begin
        case (opFunc)
            aluPkg::intAdd: begin
                simpleResult = opA + opB;
            end
            aluPkg::intSub: begin
                simpleResult = opA - opB;
            end
            aluPkg::intMul: begin
                simpleResult = opA * opB;
            end
            aluPkg::shiftLeftArith, aluPkg::shiftLeftLogic: begin
                simpleResult = opA << shamt;
            end
            aluPkg::shiftRightArith: begin
                simpleResult = $signed(opA) >>> shamt;
            end
            aluPkg::shiftRightLogic: begin
                simpleResult = opA >> shamt;
            end
            // Compares answer 0 or 1
            aluPkg::cmpEq: begin
                simpleResult = aluPkg::dataWordT'(opA == opB);
            end
            aluPkg::cmpNe: begin
                simpleResult = aluPkg::dataWordT'(opA != opB);
            end
            aluPkg::cmpGt: begin
                simpleResult = aluPkg::dataWordT'($signed(opA) > $signed(opB));
            end
            aluPkg::cmpLt: begin
                simpleResult = aluPkg::dataWordT'($signed(opA) < $signed(opB));
            end
            aluPkg::cmpGtU: begin
                simpleResult = aluPkg::dataWordT'(opA > opB);
            end
            aluPkg::cmpLtU: begin
                simpleResult = aluPkg::dataWordT'(opA < opB);
            end
            aluPkg::logicNot: begin
                simpleResult = ~opA;
            end
            aluPkg::logicAnd: begin
                simpleResult = opA & opB;
            end
            aluPkg::logicOr: begin
                simpleResult = opA | opB;
            end
            aluPkg::logicXor: begin
                simpleResult = opA ^ opB;
            end
            aluPkg::logicXnor: begin
                simpleResult = opA ~^ opB;
            end
            default: begin
                simpleResult = '0;
            end
        endcase
    end

endmodule
